// ==== filelist.f ====
+incdir+include
rtl/zynq_bridge_pkg.sv
rtl/host_csr_bank.sv
rtl/host_window_xlate.sv
rtl/dram_remap.sv
rtl/mem_profiler.sv
rtl/core_io_router.sv
rtl/zynq_bridge_top.sv
dv/zynq_bridge_tb.sv

// ==== dv/zynq_bridge_tb.sv ====
`timescale 1ns/100ps

`include "zynq_bridge_settings.svh"

module zynq_bridge_tb
   import zynq_bridge_pkg::*;
   ();

   localparam int clk_period_ns = 4;
   localparam int reset_cycles  = 8;
   localparam int reg_rounds    = 16;
   localparam int stream_len    = 40;
   localparam int prof_len      = 24;
   // each test item takes at most two cycles and the margin covers the rest
   localparam int watchdog_cycles = reset_cycles + 2 * (8 + reg_rounds) + 3 * stream_len
                                    + prof_len + 20 + 200;

   logic                      clk_i = 1'b0;
   logic                      reset_i;
   logic                      csr_wr_i;
   logic                      csr_rd_i;
   logic [`ZB_CSR_IDX_W-1:0]  csr_idx_i;
   logic [`ZB_DATA_W-1:0]     csr_wdata_i;
   logic [`ZB_DATA_W-1:0]     csr_rdata_o;
   logic                      csr_rvalid_o;
   logic                      core_reset_o;
   host_req_t                 host_req_i;
   logic                      host_v_i;
   core_req_t                 core_req_o;
   logic                      core_v_o;
   dram_req_t                 dram_req_i;
   logic                      dram_v_i;
   logic [`ZB_ADDR_W-1:0]     mem_addr_o;
   logic                      mem_write_o;
   logic                      mem_v_o;
   core_req_t                 io_req_i;
   logic                      io_v_i;
   core_req_t                 host_msg_o;
   logic                      host_msg_v_o;
   core_req_t                 periph_req_o;
   logic                      periph_v_o;

   // reference model state
   logic [`ZB_DATA_W-1:0]       ctrl_m [`ZB_NUM_CTRL_REGS];
   logic [`ZB_PROF_REGIONS-1:0] bitmap_m;
   logic [31:0]                 lfsr_state = 32'd46;
   int                          errors = 0;
   int                          checks = 0;

   zynq_bridge_top u_dut (.*);

   always #(clk_period_ns / 2.0) clk_i = ~clk_i;

   function automatic logic lfsr_step();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out)
         lfsr_state = lfsr_state ^ 32'hA300_0000;
      return out;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], lfsr_step()};
      return v;
   endfunction

   function automatic logic [31:0] readback_model(input logic [2:0] idx);
      if (idx < `ZB_NUM_CTRL_REGS)
         return ctrl_m[idx];
      else if (idx < `ZB_REG_PROF0 + 4)
         return bitmap_m[(idx - `ZB_REG_PROF0) * 32 +: 32];
      else
         return '0;
   endfunction

   task automatic check_value(input string name, input logic [64:0] exp, input logic [64:0] act);
      checks++;
      assert (exp === act)
      else
      begin
         errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      checks++;
      assert (exp === act)
      else
      begin
         errors++;
         if (exp)
            $display("%s: the valid did not rise when a result was due", name);
         else
            $display("%s: the valid rose when no result was due", name);
      end
   endtask

   // the model takes the inputs of this cycle before the clock moves on
   task automatic step_cycle();
      if (!ctrl_m[`ZB_REG_RESET][0])
         bitmap_m = '0;
      else if (dram_v_i)
         bitmap_m[dram_req_i.addr.word[`ZB_PROF_REGION_LSB +: 7]] = 1'b1;
      if (csr_wr_i && csr_idx_i < `ZB_NUM_CTRL_REGS)
         ctrl_m[csr_idx_i] = csr_wdata_i;
      @(posedge clk_i);
      #0.5;
   endtask

   task automatic csr_write(input logic [2:0] idx, input logic [31:0] data);
      csr_wr_i    = 1'b1;
      csr_idx_i   = idx;
      csr_wdata_i = data;
      step_cycle();
      csr_wr_i = 1'b0;
      check_valid("write rvalid", 1'b0, csr_rvalid_o);
   endtask

   task automatic csr_read(input logic [2:0] idx);
      logic [31:0] exp;
      exp       = readback_model(idx);
      csr_rd_i  = 1'b1;
      csr_idx_i = idx;
      step_cycle();
      csr_rd_i = 1'b0;
      check_valid($sformatf("read %0d", idx), 1'b1, csr_rvalid_o);
      check_value($sformatf("read %0d", idx), exp, csr_rdata_o);
   endtask

   initial
   begin
      logic            v;
      logic            to_host;
      logic [64:0]     exp_req;
      logic [2:0]      idx;
      logic [31:0]     addr;
      {csr_wr_i, csr_rd_i, csr_idx_i, csr_wdata_i} = '0;
      {host_req_i, host_v_i, dram_req_i, dram_v_i, io_req_i, io_v_i} = '0;
      ctrl_m   = '{default: '0};
      bitmap_m = '0;
      reset_i  = 1'b1;
      repeat (reset_cycles) @(posedge clk_i);
      #0.5;
      reset_i = 1'b0;

      // reset defaults and register access
      check_valid("reset rvalid", 1'b0, csr_rvalid_o);
      check_valid("reset core_v", 1'b0, core_v_o);
      check_valid("reset mem_v", 1'b0, mem_v_o);
      check_valid("reset host_msg_v", 1'b0, host_msg_v_o);
      check_valid("reset periph_v", 1'b0, periph_v_o);
      check_value("reset core reset", 1'b1, core_reset_o);
      for (int i = 0; i < 8; i++)
         csr_read(3'(i));
      for (int n = 0; n < reg_rounds; n++)
      begin
         idx = 3'(rand_bits(3));
         csr_write(idx, rand_bits(32));
         check_value("core reset", !ctrl_m[`ZB_REG_RESET][0], core_reset_o);
         csr_read(idx);
      end
      csr_write(`ZB_REG_RESET, 32'd1);
      check_value("core reset release", 1'b0, core_reset_o);

      // host window translation
      for (int n = 0; n < stream_len; n++)
      begin
         host_v_i         = rand_bits(2) != 0;
         host_req_i.addr  = 30'(rand_bits(30));
         host_req_i.write = lfsr_step();
         host_req_i.data  = rand_bits(32);
         exp_req = {~host_req_i.addr[29], 3'b000, host_req_i.addr[27:0], host_req_i.write,
                    host_req_i.data};
         v = host_v_i;
         step_cycle();
         check_valid("xlate", v, core_v_o);
         if (v)
            check_value("xlate", exp_req, core_req_o);
      end
      host_v_i = 1'b0;
      step_cycle();
      check_valid("xlate idle", 1'b0, core_v_o);

      // DRAM remap with back-to-back requests
      csr_write(`ZB_REG_DRAM_BASE, rand_bits(32));
      dram_v_i = 1'b1;
      for (int n = 0; n < stream_len; n++)
      begin
         dram_req_i.addr.word = rand_bits(32);
         dram_req_i.write     = lfsr_step();
         exp_req = {(dram_req_i.addr.word ^ 32'h8000_0000) + ctrl_m[`ZB_REG_DRAM_BASE],
                    dram_req_i.write};
         step_cycle();
         check_valid("remap", 1'b1, mem_v_o);
         check_value("remap", exp_req, {mem_addr_o, mem_write_o});
      end
      dram_v_i = 1'b0;
      step_cycle();
      check_valid("remap idle", 1'b0, mem_v_o);

      // profiler starts from a cleared map after a core reset
      csr_write(`ZB_REG_RESET, 32'd0);
      csr_write(`ZB_REG_RESET, 32'd1);
      for (int n = 0; n < prof_len; n++)
      begin
         dram_v_i             = lfsr_step();
         dram_req_i.addr.word = rand_bits(32);
         dram_req_i.write     = lfsr_step();
         step_cycle();
      end
      dram_v_i = 1'b0;
      for (int i = `ZB_REG_PROF0; i < `ZB_REG_PROF0 + 4; i++)
         csr_read(3'(i));
      csr_write(`ZB_REG_RESET, 32'd0);
      csr_write(`ZB_REG_RESET, 32'd1);
      for (int i = `ZB_REG_PROF0; i < `ZB_REG_PROF0 + 4; i++)
         csr_read(3'(i));

      // core I/O routing with addresses mostly close to the split
      for (int n = 0; n < stream_len; n++)
      begin
         io_v_i = rand_bits(2) != 0;
         if (rand_bits(2) == 0)
            addr = rand_bits(32);
         else
            addr = `ZB_IO_SPLIT_ADDR - 32'd128 + rand_bits(8);
         io_req_i.addr  = addr;
         io_req_i.write = lfsr_step();
         io_req_i.data  = rand_bits(32);
         exp_req = io_req_i;
         to_host = addr < 32'h0020_0000;
         v       = io_v_i;
         step_cycle();
         check_valid("io host", v && to_host, host_msg_v_o);
         check_valid("io periph", v && !to_host, periph_v_o);
         if (v && to_host)
            check_value("io host msg", exp_req, host_msg_o);
         if (v && !to_host)
            check_value("io periph req", exp_req, periph_req_o);
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   initial
   begin
      #(watchdog_cycles * clk_period_ns);
      $display("watchdog: tests did not finish within %0d cycles", watchdog_cycles);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== rtl/zynq_bridge_top.sv ====
`timescale 1ns/100ps

`include "zynq_bridge_settings.svh"

module zynq_bridge_top
   import zynq_bridge_pkg::*;
   (input  logic                      clk_i
   , input  logic                     reset_i

   // host register bank
   , input  logic                     csr_wr_i
   , input  logic                     csr_rd_i
   , input  logic [`ZB_CSR_IDX_W-1:0] csr_idx_i
   , input  logic [`ZB_DATA_W-1:0]    csr_wdata_i
   , output logic [`ZB_DATA_W-1:0]    csr_rdata_o
   , output logic                     csr_rvalid_o
   , output logic                     core_reset_o

   // host window into the core
   , input  host_req_t                host_req_i
   , input  logic                     host_v_i
   , output core_req_t                core_req_o
   , output logic                     core_v_o

   // core DRAM requests toward the host memory
   , input  dram_req_t                dram_req_i
   , input  logic                     dram_v_i
   , output logic [`ZB_ADDR_W-1:0]    mem_addr_o
   , output logic                     mem_write_o
   , output logic                     mem_v_o

   // core outbound I/O
   , input  core_req_t                io_req_i
   , input  logic                     io_v_i
   , output core_req_t                host_msg_o
   , output logic                     host_msg_v_o
   , output core_req_t                periph_req_o
   , output logic                     periph_v_o
   );

   logic [`ZB_DATA_W-1:0]       dram_base;
   logic [`ZB_PROF_REGIONS-1:0] prof_bits;

   host_csr_bank u_csr
      (.clk_i        (clk_i)
      ,.reset_i      (reset_i)
      ,.csr_wr_i     (csr_wr_i)
      ,.csr_rd_i     (csr_rd_i)
      ,.csr_idx_i    (csr_idx_i)
      ,.csr_wdata_i  (csr_wdata_i)
      ,.prof_bits_i  (prof_bits)
      ,.csr_rdata_o  (csr_rdata_o)
      ,.csr_rvalid_o (csr_rvalid_o)
      ,.dram_base_o  (dram_base)
      ,.core_reset_o (core_reset_o)
      );

   host_window_xlate u_xlate
      (.clk_i      (clk_i)
      ,.reset_i    (reset_i)
      ,.host_req_i (host_req_i)
      ,.host_v_i   (host_v_i)
      ,.core_req_o (core_req_o)
      ,.core_v_o   (core_v_o)
      );

   dram_remap u_remap
      (.clk_i       (clk_i)
      ,.reset_i     (reset_i)
      ,.dram_req_i  (dram_req_i)
      ,.dram_v_i    (dram_v_i)
      ,.dram_base_i (dram_base)
      ,.mem_addr_o  (mem_addr_o)
      ,.mem_write_o (mem_write_o)
      ,.mem_v_o     (mem_v_o)
      );

   // the profiler follows the core reset and not the system reset
   mem_profiler u_prof
      (.clk_i        (clk_i)
      ,.core_reset_i (core_reset_o)
      ,.dram_req_i   (dram_req_i)
      ,.dram_v_i     (dram_v_i)
      ,.prof_bits_o  (prof_bits)
      );

   core_io_router u_router
      (.clk_i        (clk_i)
      ,.reset_i      (reset_i)
      ,.io_req_i     (io_req_i)
      ,.io_v_i       (io_v_i)
      ,.host_msg_o   (host_msg_o)
      ,.host_msg_v_o (host_msg_v_o)
      ,.periph_req_o (periph_req_o)
      ,.periph_v_o   (periph_v_o)
      );

endmodule

// ==== rtl/core_io_router.sv ====
`timescale 1ns/100ps

`include "zynq_bridge_settings.svh"

module core_io_router
   import zynq_bridge_pkg::*;
   (input  logic       clk_i
   , input  logic      reset_i
   , input  core_req_t io_req_i
   , input  logic      io_v_i
   , output core_req_t host_msg_o
   , output logic      host_msg_v_o
   , output core_req_t periph_req_o
   , output logic      periph_v_o
   );

   logic to_host;

   // the low addresses are the host message space of the core
   assign to_host = io_req_i.addr < `ZB_IO_SPLIT_ADDR;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         host_msg_v_o <= 1'b0;
         periph_v_o   <= 1'b0;
      end
      else
      begin
         host_msg_v_o <= io_v_i & to_host;
         periph_v_o   <= io_v_i & ~to_host;
      end
   end

   // each side holds its last request until a new one is steered to it
   always_ff @(posedge clk_i)
   begin
      if (io_v_i && to_host)
         host_msg_o <= io_req_i;
      if (io_v_i && !to_host)
         periph_req_o <= io_req_i;
   end

endmodule

// ==== rtl/mem_profiler.sv ====
`timescale 1ns/100ps

`include "zynq_bridge_settings.svh"

module mem_profiler
   import zynq_bridge_pkg::*;
   (input  logic                         clk_i
   , input  logic                        core_reset_i
   , input  dram_req_t                   dram_req_i
   , input  logic                        dram_v_i
   , output logic [`ZB_PROF_REGIONS-1:0] prof_bits_o
   );

   // shows the host how much DRAM a program touches with one bit per region
   logic [`ZB_PROF_REGIONS-1:0] set_vec;
   logic [`ZB_PROF_REGIONS-1:0] bits_r;

   always_comb
   begin
      set_vec = '0;
      set_vec[dram_req_i.addr.f.region] = dram_v_i;
   end

   // the map starts over with every new run of the core
   always_ff @(posedge clk_i)
   begin
      if (core_reset_i)
      begin
         bits_r <= '0;
      end
      else
      begin
         bits_r <= bits_r | set_vec;
      end
   end

   assign prof_bits_o = bits_r;

endmodule

// ==== rtl/dram_remap.sv ====
`timescale 1ns/100ps

`include "zynq_bridge_settings.svh"

module dram_remap
   import zynq_bridge_pkg::*;
   (input  logic                   clk_i
   , input  logic                  reset_i
   , input  dram_req_t             dram_req_i
   , input  logic                  dram_v_i
   , input  logic [`ZB_DATA_W-1:0] dram_base_i
   , output logic [`ZB_ADDR_W-1:0] mem_addr_o
   , output logic                  mem_write_o
   , output logic                  mem_v_o
   );

   localparam logic [`ZB_ADDR_W-1:0] base_flip_lp = `ZB_ADDR_W'(1) << `ZB_DRAM_BASE_BIT;

   logic [`ZB_ADDR_W-1:0] offset;
   logic [`ZB_ADDR_W-1:0] remapped;

   // core DRAM starts at the base bit, so flipping it leaves the offset
   // into DRAM, which is then placed inside the block the host allocated
   assign offset   = dram_req_i.addr.word ^ base_flip_lp;
   assign remapped = offset + dram_base_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         mem_v_o <= 1'b0;
      end
      else
      begin
         mem_v_o <= dram_v_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (dram_v_i)
      begin
         mem_addr_o  <= remapped;
         mem_write_o <= dram_req_i.write;
      end
   end

endmodule

// ==== rtl/host_window_xlate.sv ====
`timescale 1ns/100ps

`include "zynq_bridge_settings.svh"

module host_window_xlate
   import zynq_bridge_pkg::*;
   (input  logic       clk_i
   , input  logic      reset_i
   , input  host_req_t host_req_i
   , input  logic      host_v_i
   , output core_req_t core_req_o
   , output logic      core_v_o
   );

   core_req_t core_req_n;

   // window at host 0x0000_0000 lands on core DRAM at 0x8000_0000, and the
   // window at host 0x2000_0000 lands on core local space at 0x0000_0000
   always_comb
   begin
      core_req_n.addr  = {~host_req_i.addr[`ZB_HOST_ADDR_W-1], 3'b000, host_req_i.addr[27:0]};
      core_req_n.write = host_req_i.write;
      core_req_n.data  = host_req_i.data;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         core_v_o <= 1'b0;
      else
         core_v_o <= host_v_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (host_v_i)
         core_req_o <= core_req_n;
   end

endmodule

// ==== rtl/host_csr_bank.sv ====
`timescale 1ns/100ps

`include "zynq_bridge_settings.svh"

module host_csr_bank
   (input  logic                         clk_i
   , input  logic                        reset_i
   , input  logic                        csr_wr_i
   , input  logic                        csr_rd_i
   , input  logic [`ZB_CSR_IDX_W-1:0]    csr_idx_i
   , input  logic [`ZB_DATA_W-1:0]       csr_wdata_i
   , input  logic [`ZB_PROF_REGIONS-1:0] prof_bits_i
   , output logic [`ZB_DATA_W-1:0]       csr_rdata_o
   , output logic                        csr_rvalid_o
   , output logic [`ZB_DATA_W-1:0]       dram_base_o
   , output logic                        core_reset_o
   );

   logic [`ZB_NUM_CTRL_REGS-1:0][`ZB_DATA_W-1:0] ctrl_r;
   logic [`ZB_DATA_W-1:0]                        rdata_n;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         ctrl_r <= '0;
      end
      else
      begin
         for (int i = 0; i < `ZB_NUM_CTRL_REGS; i++)
         begin
            // writes to the read-only profiler indices fall through here
            if (csr_wr_i && csr_idx_i == i[`ZB_CSR_IDX_W-1:0])
            begin
               ctrl_r[i] <= csr_wdata_i;
            end
         end
      end
   end

   // the core is held in reset until the host releases it, so a new
   // program can be loaded without reloading the bitstream
   assign core_reset_o = reset_i | ~ctrl_r[`ZB_REG_RESET][0];
   assign dram_base_o  = ctrl_r[`ZB_REG_DRAM_BASE];

   always_comb
   begin
      case (csr_idx_i)
         `ZB_REG_RESET:        rdata_n = ctrl_r[`ZB_REG_RESET];
         `ZB_REG_DRAM_VALID:   rdata_n = ctrl_r[`ZB_REG_DRAM_VALID];
         `ZB_REG_DRAM_BASE:    rdata_n = ctrl_r[`ZB_REG_DRAM_BASE];
         `ZB_REG_PROF0:        rdata_n = prof_bits_i[31:0];
         `ZB_REG_PROF0 + 1:    rdata_n = prof_bits_i[63:32];
         `ZB_REG_PROF0 + 2:    rdata_n = prof_bits_i[95:64];
         `ZB_REG_PROF0 + 3:    rdata_n = prof_bits_i[127:96];
         default:              rdata_n = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         csr_rvalid_o <= 1'b0;
      end
      else
      begin
         csr_rvalid_o <= csr_rd_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (csr_rd_i)
      begin
         csr_rdata_o <= rdata_n;
      end
   end

endmodule

// ==== rtl/zynq_bridge_pkg.sv ====
`include "zynq_bridge_settings.svh"

package zynq_bridge_pkg;

   // request arriving through the host window
   typedef struct packed
   {
      logic [`ZB_HOST_ADDR_W-1:0] addr;
      logic                       write;
      logic [`ZB_DATA_W-1:0]      data;
   } host_req_t;

   // request in the core's own address space
   typedef struct packed
   {
      logic [`ZB_ADDR_W-1:0] addr;
      logic                  write;
      logic [`ZB_DATA_W-1:0] data;
   } core_req_t;

   // the remap works on the whole word while the profiler only
   // looks at which 8 MB region the address falls into
   typedef union packed
   {
      logic [`ZB_ADDR_W-1:0] word;
      struct packed
      {
         logic [`ZB_ADDR_W-`ZB_PROF_REGION_LSB-`ZB_PROF_REGION_W-1:0] top;
         logic [`ZB_PROF_REGION_W-1:0]                                region;
         logic [`ZB_PROF_REGION_LSB-1:0]                              offset;
      } f;
   } dram_addr_u;

   typedef struct packed
   {
      dram_addr_u addr;
      logic       write;
   } dram_req_t;

endpackage

// ==== include/zynq_bridge_settings.svh ====
`ifndef ZYNQ_BRIDGE_SETTINGS_SVH
`define ZYNQ_BRIDGE_SETTINGS_SVH

// data and register word width
`define ZB_DATA_W 32

// core-side address width
`define ZB_ADDR_W 32

// the host window drops the top two address bits
`define ZB_HOST_ADDR_W 30

// host-written control registers and the readback index space
`define ZB_NUM_CTRL_REGS 3
`define ZB_CSR_IDX_W 3

// register 0 bit 0 is the core reset, low true
`define ZB_REG_RESET 0
`define ZB_REG_DRAM_VALID 1
`define ZB_REG_DRAM_BASE 2

// profiler words follow the control registers, lowest bitmap word first
`define ZB_REG_PROF0 3

// each profiler bit covers one 8 MB region of DRAM
`define ZB_PROF_REGIONS 128
`define ZB_PROF_REGION_W $clog2(`ZB_PROF_REGIONS)
`define ZB_PROF_REGION_LSB 23

// core I/O below this address belongs to the host
`define ZB_IO_SPLIT_ADDR 32'h0020_0000

// core DRAM starts at 0x8000_0000
`define ZB_DRAM_BASE_BIT 31

`endif
